// File: build.sh
#!/bin/sh
# Build and run the autoconfig testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module autoconfigTb \
  -o autoconfigSim

output=$(./obj_dir/autoconfigSim)
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi

// File: project.f
+incdir+rtl
rtl/autoconfig_pkg.sv
rtl/wbSlavePort.sv
rtl/autoconfigControl.sv
rtl/configRom.sv
rtl/baseRegister.sv
rtl/addressDecode.sv
rtl/autoconfigTop.sv
tests/autoconfigTb.sv

// File: rtl/addressDecode.sv
//////////////////////////////
// Board address decoder
//////////////////////////////

module addressDecode (
  input  logic [7:0]                  busAddr,
  input  autoconfig_pkg::bridgeBase_t bridgeBase,
  input  logic                        bridgeValid,
  input  autoconfig_pkg::ideBase_t    ideBase,
  input  logic                        ideValid,
  input  autoconfig_pkg::thirdBase_t  thirdBase,
  input  logic                        configured,
  output logic                        bridgeSel,
  output logic                        ideSel,
  output logic                        thirdSel
);

  logic bridgeHit;
  logic ideHit;
  logic thirdHit;

  assign bridgeHit = bridgeValid && (busAddr == bridgeBase);
  assign ideHit    = ideValid && (busAddr[7:1] == ideBase);     // 2-byte window
  assign thirdHit  = configured && (busAddr[7:5] == thirdBase); // 32-byte window

  // Bridge first, so overlapping bases still give one select
  assign bridgeSel = bridgeHit;
  assign ideSel    = ideHit && !bridgeHit;
  assign thirdSel  = thirdHit && !bridgeHit && !ideHit;

endmodule

// File: rtl/autoconfigControl.sv
//////////////////////////////
// Autoconfig sequencer
//////////////////////////////

module autoconfigControl (
  input  logic                   CLK40,
  input  logic                   RESETn,
  input  logic                   start,
  input  autoconfig_pkg::acReq_t req,
  input  logic                   configInN,
  input  logic [3:0]             romNibble,
  input  logic                   bridgeValid,
  input  logic                   ideValid,
  output logic                   done,
  output autoconfig_pkg::board_e active,
  output logic [6:0]             romOffset,
  output logic [3:0]             rdata,
  output logic [3:0]             nibble,
  output logic                   bridgeLoadLow,
  output logic                   bridgeLoadHigh,
  output logic                   ideLoadLow,
  output logic                   ideLoadHigh,
  output logic                   thirdLoadHigh,
  output logic                   configured,
  output logic                   configOutN
);

  localparam logic [6:0] BaseHighOffset = 7'h24;  // Address 48
  localparam logic [6:0] BaseLowOffset  = 7'h25;  // Address 4A

  typedef enum logic [1:0] {
    IDLE,
    READ_ACK,
    WRITE_APPLY,
    WRITE_ACK
  } state_e;

  state_e state;
  logic   chainOn;     // Chain input was active at start
  logic   applyWrite;
  logic   lowHit;
  logic   highHit;

  ////////////////////////////
  // Board selection
  ////////////////////////////

  always_comb begin
    if (!bridgeValid) begin
      active = autoconfig_pkg::BOARD_BRIDGE;
    end else if (!ideValid) begin
      active = autoconfig_pkg::BOARD_IDE;
    end else if (!configured) begin
      active = autoconfig_pkg::BOARD_THIRD;
    end else begin
      active = autoconfig_pkg::BOARD_NONE;
    end
  end

  assign romOffset = req.offset;
  assign nibble    = req.wdata;

  // Base loads, one cycle wide in WRITE_APPLY
  assign applyWrite = (state == WRITE_APPLY) && chainOn;
  assign lowHit     = applyWrite && (req.offset == BaseLowOffset);
  assign highHit    = applyWrite && (req.offset == BaseHighOffset);

  assign bridgeLoadLow  = lowHit && (active == autoconfig_pkg::BOARD_BRIDGE);
  assign bridgeLoadHigh = highHit && (active == autoconfig_pkg::BOARD_BRIDGE);
  assign ideLoadLow     = lowHit && (active == autoconfig_pkg::BOARD_IDE);
  assign ideLoadHigh    = highHit && (active == autoconfig_pkg::BOARD_IDE);
  assign thirdLoadHigh  = highHit && (active == autoconfig_pkg::BOARD_THIRD);

  ////////////////////////////
  // State machine
  ////////////////////////////

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      state      <= IDLE;
      done       <= 1'b0;
      chainOn    <= 1'b0;
      configured <= 1'b0;
      configOutN <= 1'b1;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            chainOn <= !configInN;
            state   <= req.write ? WRITE_APPLY : READ_ACK;
          end
        end
        READ_ACK: begin
          done  <= 1'b1;
          state <= IDLE;
        end
        WRITE_APPLY: begin
          state <= WRITE_ACK;
          if (thirdLoadHigh) begin  // Last board done, pass the chain on
            configured <= 1'b1;
            configOutN <= 1'b0;
          end
        end
        default: begin
          done  <= 1'b1;
          state <= IDLE;
        end
      endcase
    end
  end

  // Read nibble as presented when the access began
  always_ff @(posedge CLK40) begin
    if (state == IDLE && start && !req.write) begin
      rdata <= (configInN || configured) ? 4'hF : romNibble;
    end
  end

  doneSinglePulse: assert property (@(posedge CLK40) disable iff (!RESETn)
    done |=> !done);

  configuredSticky: assert property (@(posedge CLK40) disable iff (!RESETn)
    configured |=> configured);

endmodule

// File: rtl/autoconfigTop.sv
//////////////////////////////
// Autoconfig top level
//////////////////////////////

module autoconfigTop (
  input  logic       CLK40,
  input  logic       RESETn,
  input  logic       cyc,
  input  logic       stb,
  input  logic       we,
  input  logic [6:0] adr,
  input  logic [3:0] datIn,
  input  logic       configSpace,
  input  logic       configInN,
  input  logic       autoboot,
  input  logic [7:0] busAddr,
  output logic       ack,
  output logic [3:0] datOut,
  output logic       configured,
  output logic       configOutN,
  output logic       bridgeSel,
  output logic       ideSel,
  output logic       thirdSel
);

  autoconfig_pkg::acReq_t      req;
  autoconfig_pkg::board_e      active;
  autoconfig_pkg::bridgeBase_t bridgeBase;
  autoconfig_pkg::ideBase_t    ideBase;
  autoconfig_pkg::thirdBase_t  thirdBase;

  logic       start;
  logic       done;
  logic [3:0] rdata;
  logic [6:0] romOffset;
  logic [3:0] romNibble;
  logic [3:0] nibble;
  logic       bridgeLoadLow;
  logic       bridgeLoadHigh;
  logic       ideLoadLow;
  logic       ideLoadHigh;
  logic       thirdLoadHigh;
  logic       bridgeValid;
  logic       ideValid;

  wbSlavePort port (
    .CLK40       (CLK40),
    .RESETn      (RESETn),
    .cyc         (cyc),
    .stb         (stb),
    .we          (we),
    .configSpace (configSpace),
    .adr         (adr),
    .datIn       (datIn),
    .done        (done),
    .rdata       (rdata),
    .start       (start),
    .req         (req),
    .ack         (ack),
    .datOut      (datOut)
  );

  autoconfigControl control (
    .CLK40          (CLK40),
    .RESETn         (RESETn),
    .start          (start),
    .req            (req),
    .configInN      (configInN),
    .romNibble      (romNibble),
    .bridgeValid    (bridgeValid),
    .ideValid       (ideValid),
    .done           (done),
    .active         (active),
    .romOffset      (romOffset),
    .rdata          (rdata),
    .nibble         (nibble),
    .bridgeLoadLow  (bridgeLoadLow),
    .bridgeLoadHigh (bridgeLoadHigh),
    .ideLoadLow     (ideLoadLow),
    .ideLoadHigh    (ideLoadHigh),
    .thirdLoadHigh  (thirdLoadHigh),
    .configured     (configured),
    .configOutN     (configOutN)
  );

  configRom rom (
    .board    (active),
    .offset   (romOffset),
    .autoboot (autoboot),
    .nibble   (romNibble)
  );

  ////////////////////////////
  // Base registers
  ////////////////////////////

  baseRegister #(.T(autoconfig_pkg::bridgeBase_t)) bridgeReg (
    .CLK40    (CLK40),
    .RESETn   (RESETn),
    .nibble   (nibble),
    .loadLow  (bridgeLoadLow),
    .loadHigh (bridgeLoadHigh),
    .value    (bridgeBase),
    .valid    (bridgeValid)
  );

  baseRegister #(.T(autoconfig_pkg::ideBase_t)) ideReg (
    .CLK40    (CLK40),
    .RESETn   (RESETn),
    .nibble   (nibble),
    .loadLow  (ideLoadLow),
    .loadHigh (ideLoadHigh),
    .value    (ideBase),
    .valid    (ideValid)
  );

  baseRegister #(.T(autoconfig_pkg::thirdBase_t)) thirdReg (
    .CLK40    (CLK40),
    .RESETn   (RESETn),
    .nibble   (nibble),
    .loadLow  (1'b0),           // Single write at 48
    .loadHigh (thirdLoadHigh),
    .value    (thirdBase),
    .valid    ()
  );

  addressDecode decode (
    .busAddr     (busAddr),
    .bridgeBase  (bridgeBase),
    .bridgeValid (bridgeValid),
    .ideBase     (ideBase),
    .ideValid    (ideValid),
    .thirdBase   (thirdBase),
    .configured  (configured),
    .bridgeSel   (bridgeSel),
    .ideSel      (ideSel),
    .thirdSel    (thirdSel)
  );

endmodule

// File: rtl/autoconfig_params.svh
//////////////////////////////
// Autoconfig identity values
//////////////////////////////

`ifndef AUTOCONFIG_PARAMS_SVH
`define AUTOCONFIG_PARAMS_SVH

// Product numbers, one byte each
`define AC_BRIDGE_PID 8'd4
`define AC_IDE_PID 8'd3
`define AC_THIRD_PID 8'd200

// Manufacturer numbers
`define AC_MANUFACTURER 16'd600        // Shared by bridge and IDE
`define AC_THIRD_MANUFACTURER 16'd3643

// Serial number, same on every board
`define AC_SERIAL 32'd1

`endif

// File: rtl/autoconfig_pkg.sv
//////////////////////////////
// Autoconfig shared types
//////////////////////////////

package autoconfig_pkg;

  // One registered host access
  typedef struct packed {
    logic [6:0] offset;  // Register address bits 7:1
    logic       write;
    logic [3:0] wdata;
  } acReq_t;

  // Lowest board still waiting for its base
  typedef enum logic [1:0] {
    BOARD_BRIDGE = 2'd0,
    BOARD_IDE    = 2'd1,
    BOARD_THIRD  = 2'd2,
    BOARD_NONE   = 2'd3
  } board_e;

  // Base address holders
  typedef logic [7:0] bridgeBase_t;
  typedef logic [6:0] ideBase_t;    // Address bits 7:1
  typedef logic [2:0] thirdBase_t;

endpackage

// File: rtl/baseRegister.sv
//////////////////////////////
// Board base register
//////////////////////////////

// Supports bases of up to 8 bits
module baseRegister #(
  parameter type T = logic [7:0]
) (
  input  logic       CLK40,
  input  logic       RESETn,
  input  logic [3:0] nibble,
  input  logic       loadLow,
  input  logic       loadHigh,
  output T           value,
  output logic       valid
);

  localparam int W = $bits(T);

  logic [W-1:0] baseBits;
  logic [W-1:0] nextHigh;
  logic [W-1:0] nextLow;

  generate
    if (W > 4) begin : gWide
      assign nextHigh = {nibble, baseBits[W-5:0]};
      assign nextLow  = {baseBits[W-1:W-4], nibble[3 -: (W - 4)]};
    end else begin : gNarrow
      assign nextHigh = nibble[3 -: W];  // Whole base in one write
      assign nextLow  = baseBits;        // No low part
    end
  endgenerate

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      baseBits <= '0;
      valid    <= 1'b0;
    end else if (!valid) begin  // Locked once valid
      if (loadHigh) begin
        baseBits <= nextHigh;
        valid    <= 1'b1;
      end else if (loadLow) begin
        baseBits <= nextLow;
      end
    end
  end

  assign value = baseBits;

  noLoadWhenValid: assert property (@(posedge CLK40) disable iff (!RESETn)
    valid |-> !(loadLow || loadHigh));

endmodule

// File: rtl/configRom.sv
//////////////////////////////
// Identity nibble table
//////////////////////////////

`include "autoconfig_params.svh"

module configRom (
  input  autoconfig_pkg::board_e board,
  input  logic [6:0]             offset,
  input  logic                   autoboot,
  output logic [3:0]             nibble
);

  localparam logic [7:0]  BridgePid         = `AC_BRIDGE_PID;
  localparam logic [7:0]  IdePid            = `AC_IDE_PID;
  localparam logic [7:0]  ThirdPid          = `AC_THIRD_PID;
  localparam logic [15:0] Manufacturer      = `AC_MANUFACTURER;
  localparam logic [15:0] ThirdManufacturer = `AC_THIRD_MANUFACTURER;
  localparam logic [31:0] Serial            = `AC_SERIAL;

  logic [3:0]  typeNib;  // Offset 00
  logic [3:0]  sizeNib;  // Offset 01
  logic [3:0]  flagNib;  // Offset 04, before inversion
  logic [7:0]  pid;
  logic [15:0] mfr;
  logic [1:0]  mfrIdx;
  logic [2:0]  serIdx;

  // Per-board fields
  always_comb begin
    case (board)
      autoconfig_pkg::BOARD_BRIDGE: begin
        typeNib = 4'hC;
        sizeNib = 4'h1;
        flagNib = 4'hC;
        pid     = BridgePid;
        mfr     = Manufacturer;
      end
      autoconfig_pkg::BOARD_IDE: begin
        typeNib = {3'b110, autoboot};  // Boot ROM flag
        sizeNib = 4'h2;
        flagNib = 4'h4;
        pid     = IdePid;
        mfr     = Manufacturer;
      end
      default: begin
        typeNib = 4'h8;
        sizeNib = 4'h5;
        flagNib = 4'h7;
        pid     = ThirdPid;
        mfr     = ThirdManufacturer;
      end
    endcase
  end

  // High nibble comes first in both fields
  assign mfrIdx = 2'(7'h0B - offset);
  assign serIdx = 3'(7'h13 - offset);

  always_comb begin
    if (board == autoconfig_pkg::BOARD_NONE) begin
      nibble = 4'hF;
    end else begin
      case (offset)
        7'h00: nibble = typeNib;
        7'h01: nibble = sizeNib;
        7'h02: nibble = ~pid[7:4];
        7'h03: nibble = ~pid[3:0];
        7'h04: nibble = ~flagNib;
        7'h08, 7'h09, 7'h0A, 7'h0B: nibble = ~mfr[{mfrIdx, 2'b00} +: 4];
        7'h0C, 7'h0D, 7'h0E, 7'h0F,
        7'h10, 7'h11, 7'h12, 7'h13: nibble = ~Serial[{serIdx, 2'b00} +: 4];
        default: nibble = 4'hF;  // Unused register
      endcase
    end
  end

endmodule

// File: rtl/wbSlavePort.sv
//////////////////////////////
// Wishbone slave port
//////////////////////////////

module wbSlavePort (
  input  logic                   CLK40,
  input  logic                   RESETn,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic                   configSpace,
  input  logic [6:0]             adr,
  input  logic [3:0]             datIn,
  input  logic                   done,
  input  logic [3:0]             rdata,
  output logic                   start,
  output autoconfig_pkg::acReq_t req,
  output logic                   ack,
  output logic [3:0]             datOut
);

  logic busy;      // Access in flight
  logic newCycle;

  assign newCycle = cyc && stb && configSpace && !busy;

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      busy  <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= newCycle;  // One pulse per access
      if (newCycle) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // Request payload
  always_ff @(posedge CLK40) begin
    if (newCycle) begin
      req.offset <= adr;
      req.write  <= we;
      req.wdata  <= datIn;
    end
  end

  assign ack    = done;
  assign datOut = (done && !req.write) ? rdata : 4'h0;  // Valid with read ack only

  // Ack must only answer a live cycle
  ackInCycle: assert property (@(posedge CLK40) disable iff (!RESETn)
    $rose(ack) |-> (cyc && stb));

endmodule

// File: tests/autoconfigTb.sv
//////////////////////////////
// Autoconfig testbench
//////////////////////////////

module autoconfigTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AckTimeout = 16;  // Cycles before giving up on ack

  // One table row
  typedef struct packed {
    logic       we;
    logic [6:0] adr;
    logic [3:0] datIn;
    logic       configInN;
    logic       autoboot;
    logic [7:0] busAddr;
    logic [3:0] expData;        // Checked on reads only
    logic       expConfigured;
    logic       expConfigOutN;
    logic [2:0] expSel;         // {bridge, ide, third}
  } vector_t;

  logic       CLK40;
  logic       RESETn;
  logic       cyc;
  logic       stb;
  logic       we;
  logic [6:0] adr;
  logic [3:0] datIn;
  logic       configSpace;
  logic       configInN;
  logic       autoboot;
  logic [7:0] busAddr;
  logic       ack;
  logic [3:0] datOut;
  logic       configured;
  logic       configOutN;
  logic       bridgeSel;
  logic       ideSel;
  logic       thirdSel;

  vector_t vectors[$];
  string   names[$];
  int      errorCount;
  int      failedTests;

  autoconfigTop uut (
    .CLK40       (CLK40),
    .RESETn      (RESETn),
    .cyc         (cyc),
    .stb         (stb),
    .we          (we),
    .adr         (adr),
    .datIn       (datIn),
    .configSpace (configSpace),
    .configInN   (configInN),
    .autoboot    (autoboot),
    .busAddr     (busAddr),
    .ack         (ack),
    .datOut      (datOut),
    .configured  (configured),
    .configOutN  (configOutN),
    .bridgeSel   (bridgeSel),
    .ideSel      (ideSel),
    .thirdSel    (thirdSel)
  );

  initial begin
    CLK40 = 1'b0;
    forever #2 CLK40 = ~CLK40;  // 4 ns period
  end

  task automatic addTest(input string name, input int isWrite, input logic [6:0] a,
                         input logic [3:0] d, input int chainOff, input int boot,
                         input logic [7:0] addr, input logic [3:0] expData,
                         input int expCfg, input int expOutN, input logic [2:0] expSel);
    vector_t v;
    v.we            = (isWrite != 0);
    v.adr           = a;
    v.datIn         = d;
    v.configInN     = (chainOff != 0);
    v.autoboot      = (boot != 0);
    v.busAddr       = addr;
    v.expData       = expData;
    v.expConfigured = (expCfg != 0);
    v.expConfigOutN = (expOutN != 0);
    v.expSel        = expSel;
    vectors.push_back(v);
    names.push_back(name);
  endtask

  task automatic reportMismatch(input string test, input string what,
                                input int expected, input int actual);
    $display("Error %s: %s expected %0h actual %0h", test, what, expected, actual);
    errorCount++;
  endtask

  ////////////////////////////
  // Wishbone master
  ////////////////////////////

  task automatic runTest(input int idx);
    vector_t v;
    string   name;
    int      cycles;
    int      expCycles;
    int      errorsBefore;
    logic    gotAck;
    v            = vectors[idx];
    name         = names[idx];
    expCycles    = v.we ? 4 : 3;  // Fixed read and write latency
    errorsBefore = errorCount;
    @(posedge CLK40);
    cyc       <= 1'b1;
    stb       <= 1'b1;
    we        <= v.we;
    adr       <= v.adr;
    datIn     <= v.datIn;
    configInN <= v.configInN;
    autoboot  <= v.autoboot;
    busAddr   <= v.busAddr;
    cycles = 0;
    gotAck = 1'b0;
    while (!gotAck && cycles < AckTimeout) begin
      @(posedge CLK40);
      cycles++;
      @(negedge CLK40);  // Outputs settled
      gotAck = ack;
    end
    assert (gotAck) else begin
      $display("Test %s: no ack within %0d cycles", name, AckTimeout);
      errorCount++;
    end
    if (gotAck) begin
      assert (cycles == expCycles) else reportMismatch(name, "latency", expCycles, cycles);
      if (!v.we) begin
        assert (datOut == v.expData) else reportMismatch(name, "datOut", v.expData, datOut);
      end
      assert (configured == v.expConfigured)
        else reportMismatch(name, "configured", v.expConfigured, configured);
      assert (configOutN == v.expConfigOutN)
        else reportMismatch(name, "configOutN", v.expConfigOutN, configOutN);
      assert ({bridgeSel, ideSel, thirdSel} == v.expSel)
        else reportMismatch(name, "selects", v.expSel, {bridgeSel, ideSel, thirdSel});
    end
    @(posedge CLK40);
    cyc <= 1'b0;  // End of cycle
    stb <= 1'b0;
    we  <= 1'b0;
    if (errorCount == errorsBefore) begin
      $display("%-12s ok", name);
    end else begin
      $display("%-12s failed", name);
      failedTests++;
    end
  endtask

  ////////////////////////////
  // Stimulus table
  ////////////////////////////

  task automatic fillTable();
    // Chain input inactive
    addTest("offRd00",   0, 7'h00, 4'h0, 1, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("offWrLo",   1, 7'h25, 4'h8, 1, 0, 8'hE8, 4'h0, 0, 1, 3'b000);
    addTest("offWrHi",   1, 7'h24, 4'hE, 1, 0, 8'hE8, 4'h0, 0, 1, 3'b000);
    // Bridge identity
    addTest("brRd00",    0, 7'h00, 4'h0, 0, 0, 8'h00, 4'hC, 0, 1, 3'b000);
    addTest("brRd01",    0, 7'h01, 4'h0, 0, 0, 8'h00, 4'h1, 0, 1, 3'b000);
    addTest("brRd02",    0, 7'h02, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd03",    0, 7'h03, 4'h0, 0, 0, 8'h00, 4'hB, 0, 1, 3'b000);
    addTest("brRd04",    0, 7'h04, 4'h0, 0, 0, 8'h00, 4'h3, 0, 1, 3'b000);
    addTest("brRd05",    0, 7'h05, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd06",    0, 7'h06, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd07",    0, 7'h07, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd08",    0, 7'h08, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd09",    0, 7'h09, 4'h0, 0, 0, 8'h00, 4'hD, 0, 1, 3'b000);
    addTest("brRd0A",    0, 7'h0A, 4'h0, 0, 0, 8'h00, 4'hA, 0, 1, 3'b000);
    addTest("brRd0B",    0, 7'h0B, 4'h0, 0, 0, 8'h00, 4'h7, 0, 1, 3'b000);
    addTest("brRd0C",    0, 7'h0C, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd0D",    0, 7'h0D, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd0E",    0, 7'h0E, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd0F",    0, 7'h0F, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd10",    0, 7'h10, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd11",    0, 7'h11, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd12",    0, 7'h12, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("brRd13",    0, 7'h13, 4'h0, 0, 0, 8'h00, 4'hE, 0, 1, 3'b000);
    addTest("brRd40",    0, 7'h40, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    // Bridge base E8
    addTest("brBaseLo",  1, 7'h25, 4'h8, 0, 0, 8'hE8, 4'h0, 0, 1, 3'b000);
    addTest("brBaseHi",  1, 7'h24, 4'hE, 0, 0, 8'hE8, 4'h0, 0, 1, 3'b100);
    // IDE identity
    addTest("ideRd00a0", 0, 7'h00, 4'h0, 0, 0, 8'h00, 4'hC, 0, 1, 3'b000);
    addTest("ideRd00a1", 0, 7'h00, 4'h0, 0, 1, 8'h00, 4'hD, 0, 1, 3'b000);
    addTest("ideRd01",   0, 7'h01, 4'h0, 0, 0, 8'h00, 4'h2, 0, 1, 3'b000);
    addTest("ideRd02",   0, 7'h02, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("ideRd03",   0, 7'h03, 4'h0, 0, 0, 8'h00, 4'hC, 0, 1, 3'b000);
    addTest("ideRd04",   0, 7'h04, 4'h0, 0, 0, 8'h00, 4'hB, 0, 1, 3'b000);
    addTest("ideRd09",   0, 7'h09, 4'h0, 0, 0, 8'h00, 4'hD, 0, 1, 3'b000);
    addTest("ideRd0A",   0, 7'h0A, 4'h0, 0, 0, 8'h00, 4'hA, 0, 1, 3'b000);
    addTest("ideRd13",   0, 7'h13, 4'h0, 0, 0, 8'h00, 4'hE, 0, 1, 3'b000);
    // IDE base 3A with a two-byte window
    addTest("ideBaseLo", 1, 7'h25, 4'hA, 0, 0, 8'h3A, 4'h0, 0, 1, 3'b000);
    addTest("ideBaseHi", 1, 7'h24, 4'h3, 0, 0, 8'h3A, 4'h0, 0, 1, 3'b010);
    // Third board identity
    addTest("thRd00",    0, 7'h00, 4'h0, 0, 0, 8'h00, 4'h8, 0, 1, 3'b000);
    addTest("thRd01",    0, 7'h01, 4'h0, 0, 0, 8'h00, 4'h5, 0, 1, 3'b000);
    addTest("thRd02",    0, 7'h02, 4'h0, 0, 0, 8'h00, 4'h3, 0, 1, 3'b000);
    addTest("thRd03",    0, 7'h03, 4'h0, 0, 0, 8'h00, 4'h7, 0, 1, 3'b000);
    addTest("thRd04",    0, 7'h04, 4'h0, 0, 0, 8'h00, 4'h8, 0, 1, 3'b000);
    addTest("thRd08",    0, 7'h08, 4'h0, 0, 0, 8'h00, 4'hF, 0, 1, 3'b000);
    addTest("thRd09",    0, 7'h09, 4'h0, 0, 0, 8'h00, 4'h1, 0, 1, 3'b000);
    addTest("thRd0A",    0, 7'h0A, 4'h0, 0, 0, 8'h00, 4'hC, 0, 1, 3'b000);
    addTest("thRd0B",    0, 7'h0B, 4'h0, 0, 0, 8'h00, 4'h4, 0, 1, 3'b000);
    // Third base A0 on the last board of the chain
    addTest("thBase",    1, 7'h24, 4'hA, 0, 0, 8'hA5, 4'h0, 1, 0, 3'b001);
    // After configuration
    addTest("doneRd00",  0, 7'h00, 4'h0, 0, 0, 8'h00, 4'hF, 1, 0, 3'b000);
    addTest("doneRd02",  0, 7'h02, 4'h0, 0, 0, 8'h00, 4'hF, 1, 0, 3'b000);
    addTest("doneWrLo",  1, 7'h25, 4'h0, 0, 0, 8'hE8, 4'h0, 1, 0, 3'b100);
    addTest("doneWrHi",  1, 7'h24, 4'h2, 0, 0, 8'hA5, 4'h0, 1, 0, 3'b001);
    // Decoder sweep
    addTest("selIdeOdd", 0, 7'h00, 4'h0, 0, 0, 8'h3B, 4'hF, 1, 0, 3'b010);
    addTest("selIdeEven",0, 7'h00, 4'h0, 0, 0, 8'h3A, 4'hF, 1, 0, 3'b010);
    addTest("selBrNext", 0, 7'h00, 4'h0, 0, 0, 8'hE9, 4'hF, 1, 0, 3'b000);
    addTest("selNone",   0, 7'h00, 4'h0, 0, 0, 8'h55, 4'hF, 1, 0, 3'b000);
    addTest("selOldTh",  0, 7'h00, 4'h0, 0, 0, 8'h20, 4'hF, 1, 0, 3'b000);
  endtask

  // Outputs straight after reset
  task automatic checkReset();
    int errorsBefore;
    errorsBefore = errorCount;
    assert (ack == 1'b0) else reportMismatch("reset", "ack", 0, ack);
    assert (configured == 1'b0) else reportMismatch("reset", "configured", 0, configured);
    assert (configOutN == 1'b1) else reportMismatch("reset", "configOutN", 1, configOutN);
    assert ({bridgeSel, ideSel, thirdSel} == 3'b000)
      else reportMismatch("reset", "selects", 0, {bridgeSel, ideSel, thirdSel});
    if (errorCount == errorsBefore) begin
      $display("%-12s ok", "reset");
    end else begin
      $display("%-12s failed", "reset");
      failedTests++;
    end
  endtask

  initial begin
    RESETn      = 1'b0;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    datIn       = '0;
    configSpace = 1'b1;
    configInN   = 1'b0;
    autoboot    = 1'b0;
    busAddr     = '0;
    errorCount  = 0;
    failedTests = 0;
    fillTable();

    repeat (4) @(posedge CLK40);
    RESETn <= 1'b1;
    @(negedge CLK40);
    checkReset();

    for (int i = 0; i < vectors.size(); i++) begin
      runTest(i);
    end

    $display("Tests run %0d, failed %0d, errors %0d",
             vectors.size() + 1, failedTests, errorCount);
    if (failedTests == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
